//--- Makefile
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module threshold_trigger_top \
		source/threshold_cfg_pkg.sv source/trigger_pkg.sv \
		source/threshold_loader.sv source/dual_threshold.sv \
		source/threshold_trigger_top.sv

sim:
	verilator --binary --timing --assert --top-module tb_threshold_trigger \
		-f project.f -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run reported failure"; exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- project.f
+incdir+tb
source/threshold_cfg_pkg.sv
source/trigger_pkg.sv
source/threshold_loader.sv
source/dual_threshold.sv
source/threshold_trigger_top.sv
tb/tb_threshold_trigger.sv

//--- source/dual_threshold.sv
module dual_threshold (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         shift_i,
    input  logic                         apply_i,
    input  threshold_cfg_pkg::thr_word_t casc_i,
    output threshold_cfg_pkg::thr_word_t casc_o,
    input  trigger_pkg::env_pair_t       env_i,
    output trigger_pkg::trig_pair_t      trig_o
);
    import threshold_cfg_pkg::*;
    import trigger_pkg::*;

    thr_word_t        main_stg_q;
    thr_word_t        sub_stg_q;
    thr_word_t        main_act_q;
    thr_word_t        sub_act_q;
    logic             apply_d_q;
    env_pair_t        env_q;
    logic [CMP_W-1:0] main_diff0_q;
    logic [CMP_W-1:0] main_diff1_q;
    logic [CMP_W-1:0] sub_diff0;
    logic [CMP_W-1:0] sub_diff1;

    // Threshold minus envelope minus one, zero-extended
    // Negative exactly when the envelope reaches the threshold
    function automatic logic [CMP_W-1:0] main_diff(input thr_w_t thr, input env_w_t env);
        return CMP_W'(thr) - CMP_W'(env) - CMP_W'(1);
    endfunction

    // Staged registers form two links of the cascade
    // The main slot takes the incoming word and hands its old value to the sub slot
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            main_stg_q <= '1;
            sub_stg_q  <= '0;
        end else if (shift_i) begin
            main_stg_q <= casc_i;
            sub_stg_q  <= main_stg_q;
        end
    end

    assign casc_o = sub_stg_q;

    // Main thresholds go live on the apply cycle, sub margins one cycle later
    // The sub margin is first used one stage after the main threshold,
    // so both halves of a new setting reach the same sample
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            apply_d_q  <= 1'b0;
            main_act_q <= '1;
            sub_act_q  <= '0;
        end else begin
            apply_d_q <= apply_i;
            if (apply_i) begin
                main_act_q <= main_stg_q;
            end
            if (apply_d_q) begin
                sub_act_q <= sub_stg_q;
            end
        end
    end

    // Envelope register, then the main difference per channel
    always_ff @(posedge clk_i) begin
        env_q        <= env_i;
        main_diff0_q <= main_diff(main_act_q.ch0, env_q.ch0);
        main_diff1_q <= main_diff(main_act_q.ch1, env_q.ch1);
    end

    // The sub difference continues from the main one by taking off the margin
    // It goes negative when envelope plus margin reaches the main threshold
    assign sub_diff0 = main_diff0_q - CMP_W'(sub_act_q.ch0);
    assign sub_diff1 = main_diff1_q - CMP_W'(sub_act_q.ch1);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            trig_o <= '0;
        end else begin
            trig_o.main_ch0 <= main_diff0_q[CMP_W-1];
            trig_o.sub_ch0  <= sub_diff0[CMP_W-1];
            trig_o.main_ch1 <= main_diff1_q[CMP_W-1];
            trig_o.sub_ch1  <= sub_diff1[CMP_W-1];
        end
    end

    // Envelope and threshold paths must both be settled once out of reset
    a_trig_known : assert property (
        @(posedge clk_i) disable iff (reset_i)
        !$isunknown(trig_o)
    ) else $error("dual_threshold: trig_o unknown after reset");

endmodule

//--- source/threshold_cfg_pkg.sv
package threshold_cfg_pkg;

    // Width of one threshold value
    localparam int THR_W = 18;

    // Unsigned threshold, compared against an envelope of the same width
    typedef logic [THR_W-1:0] thr_w_t;

    // One word of the threshold cascade, one value per channel of a pair
    // A main slot holds main thresholds and a sub slot holds sub margins
    typedef struct packed {
        thr_w_t ch1;
        thr_w_t ch0;
    } thr_word_t;

    // Loader command opcodes
    // CFG_WRITE shifts one word into the chain
    // CFG_APPLY moves every staged word into the active registers
    typedef enum logic {
        CFG_WRITE = 1'b0,
        CFG_APPLY = 1'b1
    } cfg_op_e;

    // Command presented together with a single-cycle valid strobe
    // The word field is ignored for CFG_APPLY
    typedef struct packed {
        cfg_op_e   op;
        thr_word_t word;
    } cfg_cmd_t;

endpackage

//--- source/threshold_loader.sv
module threshold_loader #(
    parameter int NUM_PAIRS = 4
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         cmd_valid_i,
    input  threshold_cfg_pkg::cfg_cmd_t  cmd_i,
    output logic                         shift_o,
    output logic                         apply_o,
    output threshold_cfg_pkg::thr_word_t word_o,
    output logic                         loaded_o
);
    import threshold_cfg_pkg::*;

    // Two slots per pair, a main slot and a sub slot
    localparam int SLOTS = 2 * NUM_PAIRS;
    localparam int CNT_W = $clog2(SLOTS + 1);

    logic             wr_hit;
    logic             ap_hit;
    logic [CNT_W-1:0] fill_q;

    // Decode of the command accepted in this cycle
    assign wr_hit = cmd_valid_i && (cmd_i.op == CFG_WRITE);
    assign ap_hit = cmd_valid_i && (cmd_i.op == CFG_APPLY);

    // Strobes leave one cycle after the command is accepted
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            shift_o <= 1'b0;
            apply_o <= 1'b0;
        end else begin
            shift_o <= wr_hit;
            apply_o <= ap_hit;
        end
    end

    // The word only matters in the cycle that shift_o is high
    always_ff @(posedge clk_i) begin
        if (wr_hit) begin
            word_o <= cmd_i.word;
        end
    end

    // Counts writes since reset or the last apply
    // Extra writes past a full chain push old words out the far end,
    // so the count simply holds at full
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fill_q <= '0;
        end else if (ap_hit) begin
            fill_q <= '0;
        end else if (wr_hit && (fill_q != CNT_W'(SLOTS))) begin
            fill_q <= fill_q + CNT_W'(1);
        end
    end

    assign loaded_o = (fill_q == CNT_W'(SLOTS));

    // A command is either a write or an apply, never both
    a_strobe_excl : assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(shift_o && apply_o)
    ) else $error("threshold_loader: shift_o and apply_o high together");

endmodule

//--- source/threshold_trigger_top.sv
module threshold_trigger_top #(
    parameter int NUM_PAIRS = 4
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        cmd_valid_i,
    input  threshold_cfg_pkg::cfg_cmd_t cmd_i,
    input  trigger_pkg::env_pair_t      env_i [NUM_PAIRS],
    output trigger_pkg::trig_pair_t     trig_o [NUM_PAIRS],
    output logic                        loaded_o
);
    import threshold_cfg_pkg::*;

    logic      shift;
    logic      apply;

    // Cascade input of each block, element 0 comes from the loader
    thr_word_t casc [NUM_PAIRS];

    threshold_loader #(
        .NUM_PAIRS (NUM_PAIRS)
    ) u_loader (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .shift_o     (shift),
        .apply_o     (apply),
        .word_o      (casc[0]),
        .loaded_o    (loaded_o)
    );

    // Words enter at block 0 and move toward the last block
    for (genvar i = 0; i < NUM_PAIRS; i++) begin : g_pair
        if (i == NUM_PAIRS - 1) begin : g_last
            // End of the chain, words shifted out here are dropped
            dual_threshold u_dual (
                .clk_i   (clk_i),
                .reset_i (reset_i),
                .shift_i (shift),
                .apply_i (apply),
                .casc_i  (casc[i]),
                .casc_o  (),
                .env_i   (env_i[i]),
                .trig_o  (trig_o[i])
            );
        end else begin : g_link
            dual_threshold u_dual (
                .clk_i   (clk_i),
                .reset_i (reset_i),
                .shift_i (shift),
                .apply_i (apply),
                .casc_i  (casc[i]),
                .casc_o  (casc[i+1]),
                .env_i   (env_i[i]),
                .trig_o  (trig_o[i])
            );
        end
    end

endmodule

//--- source/trigger_pkg.sv
package trigger_pkg;

    // Width of one envelope sample
    localparam int ENV_W = 18;

    // Width of the difference arithmetic
    // The sign bit of the difference marks a trigger
    localparam int CMP_W = 24;

    // Unsigned envelope sample, one per channel per clock
    typedef logic [ENV_W-1:0] env_w_t;

    // Envelopes of the two channels handled by one dual threshold block
    typedef struct packed {
        env_w_t ch1;
        env_w_t ch0;
    } env_pair_t;

    // Trigger outputs of one pair
    // Bit 0 is the channel 0 main trigger, bit 3 the channel 1 sub trigger
    typedef struct packed {
        logic sub_ch1;
        logic main_ch1;
        logic sub_ch0;
        logic main_ch0;
    } trig_pair_t;

endpackage

//--- tb/trigger_checks.svh
`ifndef TRIGGER_CHECKS_SVH
`define TRIGGER_CHECKS_SVH

// Shadow copy of the loader strobes, fill count and threshold registers
logic      m_shift;
logic      m_apply;
logic      m_apply_d;
thr_word_t m_word;
int        m_fill;
thr_word_t m_main_stg [NUM_PAIRS];
thr_word_t m_sub_stg  [NUM_PAIRS];
thr_word_t m_main_act [NUM_PAIRS];
thr_word_t m_sub_act  [NUM_PAIRS];

// Expected trigger bits for one pair, straight from the threshold rules
function automatic trig_pair_t ref_trigger(input thr_word_t main_thr, input thr_word_t sub_thr,
                                           input env_pair_t env);
    trig_pair_t t;
    t.main_ch0 = ({2'b00, env.ch0} >= {2'b00, main_thr.ch0});
    t.main_ch1 = ({2'b00, env.ch1} >= {2'b00, main_thr.ch1});
    t.sub_ch0  = ({2'b00, env.ch0} + {2'b00, sub_thr.ch0} >= {2'b00, main_thr.ch0});
    t.sub_ch1  = ({2'b00, env.ch1} + {2'b00, sub_thr.ch1} >= {2'b00, main_thr.ch1});
    return t;
endfunction

task automatic model_reset();
    m_shift   = 1'b0;
    m_apply   = 1'b0;
    m_apply_d = 1'b0;
    m_fill    = 0;
    for (int p = 0; p < NUM_PAIRS; p++) begin
        m_main_stg[p] = '1;
        m_sub_stg[p]  = '0;
        m_main_act[p] = '1;
        m_sub_act[p]  = '0;
    end
endtask

// One clock edge of the threshold path, given the command seen at that edge
task automatic model_edge(input logic valid, input cfg_cmd_t cmd);
    thr_word_t n_main [NUM_PAIRS];
    thr_word_t n_sub  [NUM_PAIRS];
    for (int p = 0; p < NUM_PAIRS; p++) begin
        n_main[p] = m_main_stg[p];
        n_sub[p]  = m_sub_stg[p];
        if (m_shift) begin
            n_sub[p] = m_main_stg[p];
            if (p == 0) begin
                n_main[p] = m_word;
            end else begin
                n_main[p] = m_sub_stg[p-1];
            end
        end
        if (m_apply) begin
            m_main_act[p] = m_main_stg[p];
        end
        if (m_apply_d) begin
            m_sub_act[p] = m_sub_stg[p];
        end
    end
    for (int p = 0; p < NUM_PAIRS; p++) begin
        m_main_stg[p] = n_main[p];
        m_sub_stg[p]  = n_sub[p];
    end
    m_apply_d = m_apply;
    m_shift   = valid && (cmd.op == CFG_WRITE);
    m_apply   = valid && (cmd.op == CFG_APPLY);
    if (valid && (cmd.op == CFG_WRITE)) begin
        m_word = cmd.word;
    end
    if (valid && (cmd.op == CFG_APPLY)) begin
        m_fill = 0;
    end else if (valid && (m_fill < 2 * NUM_PAIRS)) begin
        m_fill = m_fill + 1;
    end
endtask

task automatic check_trig(input int pair, input trig_pair_t got, input trig_pair_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED trig_o[%0d] got %h expected %h", pair, got, exp);
    end
endtask

task automatic check_loaded(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED loaded_o got %h expected %h", got, exp);
    end
endtask

`endif

//--- tb/tb_threshold_trigger.sv
module tb_threshold_trigger;
    import threshold_cfg_pkg::*;
    import trigger_pkg::*;

    localparam int NUM_PAIRS = 4;
    localparam int SWEEP_LEN = NUM_PAIRS * 2 * 6 + 4;
    localparam int SET_LEN   = NUM_PAIRS * 4 + 4;
    // Summed test lengths in cycles plus a margin on top
    localparam int CYCLE_LIMIT = 60 + (SET_LEN + SWEEP_LEN) + SWEEP_LEN
                                + (2 * SET_LEN + 3 * SWEEP_LEN + 10) + 2010 + 200;

    logic       clk_i;
    logic       reset_i;
    logic       cmd_valid_i;
    cfg_cmd_t   cmd_i;
    env_pair_t  env_i [NUM_PAIRS];
    trig_pair_t trig_o [NUM_PAIRS];
    logic       loaded_o;

    int         errors;
    int         checks;
    int         tests;
    int         err_mark;
    int         cycles;
    integer     seed;

    trig_pair_t exp_trig [NUM_PAIRS];
    logic       exp_loaded;
    // Samples on their way through the two compare stages
    env_pair_t  p1_env  [NUM_PAIRS];
    thr_word_t  p1_main [NUM_PAIRS];
    env_pair_t  p2_env  [NUM_PAIRS];
    thr_word_t  p2_main [NUM_PAIRS];
    thr_word_t  p2_sub  [NUM_PAIRS];

    // Threshold set that the tests write as main and sub words per block
    thr_word_t  set_main [NUM_PAIRS];
    thr_word_t  set_sub  [NUM_PAIRS];

    `include "trigger_checks.svh"

    threshold_trigger_top #(
        .NUM_PAIRS (NUM_PAIRS)
    ) uut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .env_i       (env_i),
        .trig_o      (trig_o),
        .loaded_o    (loaded_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // The compare process sees inputs and outputs as they were before each edge
    always @(posedge clk_i) begin
        if (reset_i) begin
            model_reset();
            for (int p = 0; p < NUM_PAIRS; p++) begin
                exp_trig[p] = '0;
            end
        end else begin
            for (int p = 0; p < NUM_PAIRS; p++) begin
                check_trig(p, trig_o[p], exp_trig[p]);
            end
            check_loaded(loaded_o, exp_loaded);
            for (int p = 0; p < NUM_PAIRS; p++) begin
                exp_trig[p] = ref_trigger(p2_main[p], p2_sub[p], p2_env[p]);
            end
            model_edge(cmd_valid_i, cmd_i);
        end
        for (int p = 0; p < NUM_PAIRS; p++) begin
            p2_env[p]  = p1_env[p];
            p2_main[p] = p1_main[p];
            p2_sub[p]  = m_sub_act[p];
            p1_env[p]  = env_i[p];
            p1_main[p] = m_main_act[p];
        end
        exp_loaded = (m_fill == 2 * NUM_PAIRS);
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic send_cmd(input cfg_op_e op, input thr_word_t word);
        @(posedge clk_i);
        cmd_valid_i <= 1'b1;
        cmd_i       <= '{op: op, word: word};
        @(posedge clk_i);
        cmd_valid_i <= 1'b0;
    endtask

    // Drives one channel and holds every other channel at zero
    task automatic drive_one(input int p, input int ch, input int value);
        logic [31:0] v;
        if (value < 0) begin
            v = 0;
        end else if (value > 32'h3ffff) begin
            v = 32'h3ffff;
        end else begin
            v = value;
        end
        @(posedge clk_i);
        for (int q = 0; q < NUM_PAIRS; q++) begin
            env_i[q] <= '0;
        end
        if (ch == 0) begin
            env_i[p].ch0 <= v[17:0];
        end else begin
            env_i[p].ch1 <= v[17:0];
        end
    endtask

    // Ends between edges so the last compare of the flush is already counted
    task automatic flush();
        @(posedge clk_i);
        for (int q = 0; q < NUM_PAIRS; q++) begin
            env_i[q] <= '0;
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
    endtask

    // First word lands in the sub slot of the last block
    task automatic write_set(input logic check_fill);
        int blk;
        for (int i = 0; i < 2 * NUM_PAIRS; i++) begin
            blk = NUM_PAIRS - 1 - i / 2;
            if (i % 2 == 0) begin
                send_cmd(CFG_WRITE, set_sub[blk]);
            end else begin
                send_cmd(CFG_WRITE, set_main[blk]);
            end
            if (check_fill) begin
                @(negedge clk_i);
                check_loaded(loaded_o, (i == 2 * NUM_PAIRS - 1));
            end
        end
    endtask

    task automatic sweep_main(input thr_word_t mains [NUM_PAIRS]);
        int thr;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            for (int ch = 0; ch < 2; ch++) begin
                thr = (ch == 0) ? int'(mains[p].ch0) : int'(mains[p].ch1);
                for (int d = -2; d <= 3; d++) begin
                    drive_one(p, ch, thr + d);
                end
            end
        end
        flush();
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %0d %s: %s, %0d errors", tests, name,
                 (errors == err_mark) ? "ok" : "mismatch", errors - err_mark);
        err_mark = errors;
    endtask

    task automatic make_set(input int base);
        for (int p = 0; p < NUM_PAIRS; p++) begin
            set_main[p].ch0 = 18'(base + 20000 * p);
            set_main[p].ch1 = 18'(base + 20000 * p + 7000);
            set_sub[p].ch0  = 18'(100 + 30 * p);
            set_sub[p].ch1  = 18'(250 + 30 * p);
        end
    endtask

    initial begin
        thr_word_t   old_main [NUM_PAIRS];
        thr_word_t   cur_sub  [NUM_PAIRS];
        logic [31:0] r;
        logic [31:0] w;
        int          thr;
        int          sub;

        errors      = 0;
        checks      = 0;
        tests       = 0;
        err_mark    = 0;
        cycles      = 0;
        seed        = 32'h28ef4326;
        reset_i     = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            env_i[p] = '0;
        end
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;

        // Nothing below all ones may trigger before the first apply
        for (int c = 0; c < 50; c++) begin
            @(posedge clk_i);
            for (int p = 0; p < NUM_PAIRS; p++) begin
                r = $random(seed);
                w = $random(seed);
                env_i[p] <= '{ch1: (w[17:0] == '1) ? '0 : w[17:0],
                              ch0: (r[17:0] == '1) ? '0 : r[17:0]};
            end
        end
        flush();
        @(negedge clk_i);
        check_loaded(loaded_o, 1'b0);
        end_test("reset state");

        make_set(5000);
        write_set(1'b1);
        send_cmd(CFG_APPLY, '0);
        @(negedge clk_i);
        check_loaded(loaded_o, 1'b0);
        flush();
        sweep_main(set_main);
        end_test("load and main sweep");

        // Envelopes around the band between main minus margin and main
        for (int p = 0; p < NUM_PAIRS; p++) begin
            for (int ch = 0; ch < 2; ch++) begin
                thr = (ch == 0) ? int'(set_main[p].ch0) : int'(set_main[p].ch1);
                sub = (ch == 0) ? int'(set_sub[p].ch0) : int'(set_sub[p].ch1);
                drive_one(p, ch, thr - sub - 1);
                drive_one(p, ch, thr - sub);
                drive_one(p, ch, thr - sub / 2);
                drive_one(p, ch, thr - 1);
                drive_one(p, ch, thr);
                drive_one(p, ch, thr + 1);
            end
        end
        flush();
        end_test("subthreshold");

        old_main = set_main;
        make_set(9000);
        for (int p = 0; p < NUM_PAIRS; p++) begin
            set_sub[p].ch0 = set_sub[p].ch0 + 18'd500;
            set_sub[p].ch1 = set_sub[p].ch1 + 18'd500;
        end
        cur_sub = set_sub;
        write_set(1'b0);
        sweep_main(old_main);
        sweep_main(set_main);
        // Envelopes keep moving across the apply so every switch cycle is seen
        fork
            send_cmd(CFG_APPLY, '0);
            begin
                for (int c = 0; c < 8; c++) begin
                    @(posedge clk_i);
                    for (int p = 0; p < NUM_PAIRS; p++) begin
                        env_i[p] <= '{ch1: set_main[p].ch1 - cur_sub[p].ch1 / 2,
                                      ch0: (c % 2 == 0) ? set_main[p].ch0
                                                        : old_main[p].ch0};
                    end
                end
            end
        join
        flush();
        sweep_main(set_main);
        end_test("staging isolation");

        for (int c = 0; c < 2000; c++) begin
            @(posedge clk_i);
            for (int p = 0; p < NUM_PAIRS; p++) begin
                r = $random(seed);
                w = $random(seed);
                env_i[p] <= '{ch1: w[17:0], ch0: r[17:0]};
            end
            r = $random(seed);
            w = $random(seed);
            cmd_valid_i <= (r[7:0] < 8'd34);
            cmd_i.op    <= (r[7:0] < 8'd8) ? CFG_APPLY : CFG_WRITE;
            cmd_i.word  <= '{ch1: w[17:0], ch0: {w[31:18], r[31:28]}};
        end
        @(posedge clk_i);
        cmd_valid_i <= 1'b0;
        flush();
        end_test("random soak");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
